//--- src.f
src/game_pkg.sv
src/vga_if.sv
src/vga_timing.sv
src/charge_fsm.sv
src/draw_background.sv
src/draw_power_bar.sv
src/throw_meter_top.sv
testbench/tb_throw_meter.sv

//--- src/charge_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module charge_fsm import game_pkg::*; #(
    parameter int unsigned STEP_INTERVAL = 1_234_177
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   space,
    output logic   charging,
    output width_t bar_width,
    output width_t throw_force,
    output logic   throw_valid
);

    logic          space_meta;
    logic          space_sync;
    charge_state_t state;
    charge_state_t state_nxt;
    logic [31:0]   prescale;
    logic          step;

    // button comes from outside the clock domain
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            space_meta <= 1'b0;
            space_sync <= 1'b0;
        end else begin
            space_meta <= space;
            space_sync <= space_meta;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:     if (space_sync) state_nxt = ST_CHARGING;
            ST_CHARGING: if (!space_sync) state_nxt = ST_RELEASED;
            default:     state_nxt = ST_IDLE;   // released lasts one cycle
        endcase
    end

    assign step = (prescale == STEP_INTERVAL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ST_IDLE;
            prescale    <= '0;
            bar_width   <= '0;
            throw_force <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_CHARGING) begin
                if (!space_sync) begin
                    throw_force <= bar_width;
                end else if (step) begin
                    prescale <= '0;
                    if (bar_width < BAR_MAX_WIDTH) bar_width <= bar_width + 1'b1;
                end else begin
                    prescale <= prescale + 1'b1;
                end
            end else begin
                prescale  <= '0;
                bar_width <= '0;
            end
        end
    end

    assign charging    = (state == ST_CHARGING);
    assign throw_valid = (state == ST_RELEASED);

endmodule

`default_nettype wire

//--- src/draw_background.sv
`timescale 1ns/1ps
`default_nettype none

module draw_background import game_pkg::*; (
    input  logic clk,
    input  logic rst,
    vga_if.in    vga_in,
    vga_if.out   vga_out
);

    rgb_t rgb_nxt;

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            rgb_nxt = '0;
        end else if (vga_in.vcount >= GROUND_Y) begin
            rgb_nxt = GROUND_RGB;
        end else begin
            rgb_nxt = SKY_RGB;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_out.hsync <= 1'b1;
            vga_out.vsync <= 1'b1;
            vga_out.hblnk <= 1'b0;
            vga_out.vblnk <= 1'b0;
        end else begin
            vga_out.hsync <= vga_in.hsync;
            vga_out.vsync <= vga_in.vsync;
            vga_out.hblnk <= vga_in.hblnk;
            vga_out.vblnk <= vga_in.vblnk;
        end
    end

    always_ff @(posedge clk) begin
        vga_out.hcount <= vga_in.hcount;
        vga_out.vcount <= vga_in.vcount;
        vga_out.rgb    <= rgb_nxt;
    end

endmodule

`default_nettype wire

//--- src/draw_power_bar.sv
`timescale 1ns/1ps
`default_nettype none

module draw_power_bar import game_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   charging,
    input  width_t bar_width,
    vga_if.in      vga_in,
    vga_if.out     vga_out
);

    // inner box is the full bar area, outer box adds the frame
    localparam hcount_t IN_X1  = BAR_X + hcount_t'(BAR_MAX_WIDTH);
    localparam hcount_t OUT_X0 = BAR_X - hcount_t'(BAR_BORDER);
    localparam hcount_t OUT_X1 = IN_X1 + hcount_t'(BAR_BORDER);
    localparam vcount_t OUT_Y0 = BAR_Y_START - vcount_t'(BAR_BORDER);
    localparam vcount_t OUT_Y1 = BAR_Y_END + vcount_t'(BAR_BORDER);

    hcount_t bar_x_end;
    logic    in_outer;
    logic    in_inner;
    logic    on_bar;
    logic    on_border;
    rgb_t    rgb_nxt;

    assign bar_x_end = BAR_X + hcount_t'(bar_width);

    always_comb begin
        in_outer = (vga_in.hcount >= OUT_X0) && (vga_in.hcount < OUT_X1) &&
                   (vga_in.vcount >= OUT_Y0) && (vga_in.vcount < OUT_Y1);
        in_inner = (vga_in.hcount >= BAR_X) && (vga_in.hcount < IN_X1) &&
                   (vga_in.vcount >= BAR_Y_START) && (vga_in.vcount < BAR_Y_END);

        on_border = charging && in_outer && !in_inner;
        on_bar    = charging && in_inner && (vga_in.hcount < bar_x_end);
    end

    always_comb begin
        if (on_border) begin
            rgb_nxt = BORDER_RGB;
        end else if (on_bar) begin
            rgb_nxt = BAR_RGB;
        end else begin
            rgb_nxt = vga_in.rgb;   // unfilled part of the bar shows background
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_out.hsync <= 1'b1;
            vga_out.vsync <= 1'b1;
            vga_out.hblnk <= 1'b0;
            vga_out.vblnk <= 1'b0;
        end else begin
            vga_out.hsync <= vga_in.hsync;
            vga_out.vsync <= vga_in.vsync;
            vga_out.hblnk <= vga_in.hblnk;
            vga_out.vblnk <= vga_in.vblnk;
        end
    end

    always_ff @(posedge clk) begin
        vga_out.hcount <= vga_in.hcount;
        vga_out.vcount <= vga_in.vcount;
        vga_out.rgb    <= rgb_nxt;
    end

endmodule

`default_nettype wire

//--- src/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [11:0] rgb_t;     // 4 bits each, r g b
    typedef logic [9:0]  width_t;   // bar width, also the throw force

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHARGING,
        ST_RELEASED
    } charge_state_t;

    // 1024x768 timing, both sync pulses active low
    localparam hcount_t H_ACTIVE = 11'd1024;
    localparam hcount_t H_FRONT  = 11'd24;
    localparam hcount_t H_SYNC   = 11'd136;
    localparam hcount_t H_TOTAL  = 11'd1344;

    localparam vcount_t V_ACTIVE = 10'd768;
    localparam vcount_t V_FRONT  = 10'd3;
    localparam vcount_t V_SYNC   = 10'd6;
    localparam vcount_t V_TOTAL  = 10'd806;

    localparam hcount_t BAR_X         = 11'd876;
    localparam vcount_t BAR_Y_START   = 10'd400;
    localparam vcount_t BAR_Y_END     = 10'd421;   // first row below the bar
    localparam width_t  BAR_MAX_WIDTH = 10'd128;
    localparam int      BAR_BORDER    = 3;

    localparam rgb_t SKY_RGB    = 12'h6AF;
    localparam rgb_t GROUND_RGB = 12'h5A3;
    localparam rgb_t BAR_RGB    = 12'hF00;
    localparam rgb_t BORDER_RGB = 12'h000;

    localparam vcount_t GROUND_Y = 10'd600;

endpackage

`default_nettype wire

//--- src/throw_meter_top.sv
`timescale 1ns/1ps
`default_nettype none

module throw_meter_top import game_pkg::*; #(
    parameter int unsigned STEP_INTERVAL = 1_234_177
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   space,
    output logic   hsync,
    output logic   vsync,
    output rgb_t   rgb,
    output width_t throw_force,
    output logic   throw_valid
);

    logic   charging;
    width_t bar_width;

    vga_if timing_bus ();
    vga_if bg_bus ();
    vga_if bar_bus ();

    vga_timing u_vga_timing (
        .clk     (clk),
        .rst     (rst),
        .vga_out (timing_bus.out)
    );

    charge_fsm #(
        .STEP_INTERVAL (STEP_INTERVAL)
    ) u_charge_fsm (
        .clk         (clk),
        .rst         (rst),
        .space       (space),
        .charging    (charging),
        .bar_width   (bar_width),
        .throw_force (throw_force),
        .throw_valid (throw_valid)
    );

    draw_background u_draw_background (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (timing_bus.in),
        .vga_out (bg_bus.out)
    );

    draw_power_bar u_draw_power_bar (
        .clk       (clk),
        .rst       (rst),
        .charging  (charging),
        .bar_width (bar_width),
        .vga_in    (bg_bus.in),
        .vga_out   (bar_bus.out)
    );

    // two register stages behind the timing counters
    assign hsync = bar_bus.hsync;
    assign vsync = bar_bus.vsync;
    assign rgb   = bar_bus.rgb;

endmodule

`default_nettype wire

//--- src/vga_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vga_if import game_pkg::*; ();

    hcount_t hcount;
    vcount_t vcount;
    logic    hsync;
    logic    vsync;
    logic    hblnk;
    logic    vblnk;
    rgb_t    rgb;

    modport in (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

    modport out (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

endinterface

`default_nettype wire

//--- src/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing import game_pkg::*; (
    input  logic clk,
    input  logic rst,
    vga_if.out   vga_out
);

    hcount_t h_cnt;
    hcount_t h_next;
    vcount_t v_cnt;
    vcount_t v_next;
    logic    line_end;

    assign line_end = (h_cnt == H_TOTAL - 1);

    always_comb begin
        h_next = line_end ? '0 : h_cnt + 1'b1;
        v_next = v_cnt;
        if (line_end) begin
            v_next = (v_cnt == V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
        end
    end

    // sync and blank decoded from the next position so they line up with the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt         <= '0;
            v_cnt         <= '0;
            vga_out.hsync <= 1'b1;
            vga_out.vsync <= 1'b1;
            vga_out.hblnk <= 1'b0;
            vga_out.vblnk <= 1'b0;
        end else begin
            h_cnt <= h_next;
            v_cnt <= v_next;

            vga_out.hsync <= !(h_next >= H_ACTIVE + H_FRONT &&
                               h_next <  H_ACTIVE + H_FRONT + H_SYNC);
            vga_out.vsync <= !(v_next >= V_ACTIVE + V_FRONT &&
                               v_next <  V_ACTIVE + V_FRONT + V_SYNC);

            vga_out.hblnk <= (h_next >= H_ACTIVE);
            vga_out.vblnk <= (v_next >= V_ACTIVE);
        end
    end

    assign vga_out.hcount = h_cnt;
    assign vga_out.vcount = v_cnt;
    assign vga_out.rgb    = '0;     // colour is added by the draw stages

endmodule

`default_nettype wire

//--- testbench/tb_throw_meter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_throw_meter import game_pkg::*; ();

    localparam int STEP_INTERVAL  = 15;
    localparam int STEP_CYCLES    = STEP_INTERVAL + 1;    // one width step
    localparam int FRAME_CYCLES   = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 10_000;

    logic   clk = 1'b0;
    logic   rst;
    logic   space;
    logic   hsync;
    logic   vsync;
    rgb_t   rgb;
    width_t throw_force;
    logic   throw_valid;

    // outputs captured on the falling edge, with the raster position they belong to
    logic   smp_hsync;
    logic   smp_vsync;
    rgb_t   smp_rgb;
    width_t smp_force;
    logic   smp_valid;
    logic   prev_vsync = 1'b1;
    logic   pos_known = 1'b0;
    int     pos_h = 0;
    int     pos_v = 0;
    int     cycle_cnt = 0;
    int     vs_falls = 0;
    int     last_fall = 0;
    int     prev_fall = 0;
    int     errors = 0;
    int     checks = 0;

    throw_meter_top #(
        .STEP_INTERVAL (STEP_INTERVAL)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .space       (space),
        .hsync       (hsync),
        .vsync       (vsync),
        .rgb         (rgb),
        .throw_force (throw_force),
        .throw_valid (throw_valid)
    );

    always #10 clk = ~clk;

    always @(negedge clk) begin
        cycle_cnt++;
        if (prev_vsync && !vsync) begin
            pos_h     = 0;
            pos_v     = V_ACTIVE + V_FRONT;    // vsync falls at column 0 of this row
            pos_known = 1'b1;
            prev_fall = last_fall;
            last_fall = cycle_cnt;
            vs_falls++;
        end else if (pos_known) begin
            if (pos_h == H_TOTAL - 1) begin
                pos_h = 0;
                pos_v = (pos_v == V_TOTAL - 1) ? 0 : pos_v + 1;
            end else begin
                pos_h++;
            end
        end
        prev_vsync = vsync;
        smp_hsync  = hsync;
        smp_vsync  = vsync;
        smp_rgb    = rgb;
        smp_force  = throw_force;
        smp_valid  = throw_valid;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            $display("Error at %0t: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
    endtask

    task automatic wait_for_pos(input int h, input int v);
        while (!(pos_known && pos_h == h && pos_v == v)) tick();
    endtask

    // colour a pixel should have, from the screen layout
    function automatic rgb_t expected_pixel(input int h, input int v, input logic bar_on,
                                            input int w);
        rgb_t px;
        logic in_outer;
        logic in_inner;
        if (h >= H_ACTIVE || v >= V_ACTIVE) px = 12'h000;
        else if (v >= GROUND_Y) px = GROUND_RGB;
        else px = SKY_RGB;
        in_outer = h >= BAR_X - BAR_BORDER && h < BAR_X + BAR_MAX_WIDTH + BAR_BORDER &&
                   v >= BAR_Y_START - BAR_BORDER && v < BAR_Y_END + BAR_BORDER;
        in_inner = h >= BAR_X && h < BAR_X + BAR_MAX_WIDTH &&
                   v >= BAR_Y_START && v < BAR_Y_END;
        if (bar_on && in_outer && !in_inner) px = BORDER_RGB;
        else if (bar_on && in_inner && h < BAR_X + w) px = BAR_RGB;
        return px;
    endfunction

    task automatic hold_and_release(input int hold_cycles);
        tick();
        space <= 1'b1;
        repeat (hold_cycles) tick();
        space <= 1'b0;
    endtask

    task automatic await_throw(input int expected, input string what);
        int waited;
        int pulses;
        waited = 0;
        while (!smp_valid && waited < 64) begin
            tick();
            waited++;
        end
        if (!smp_valid) begin
            $display("%s: throw_valid never went high after the button was released", what);
            errors++;
        end else begin
            check(smp_force, expected, {what, " force"});
            pulses = 0;
            repeat (32) begin
                if (smp_valid) pulses++;
                tick();
            end
            check(pulses, 1, {what, " valid pulses"});
        end
    endtask

    // whole frame from the vsync fall, button up, so no bar anywhere
    task automatic background_frame();
        repeat (FRAME_CYCLES) begin
            check(smp_rgb, expected_pixel(pos_h, pos_v, 1'b0, 0),
                  $sformatf("background rgb at (%0d,%0d)", pos_h, pos_v));
            tick();
        end
    endtask

    task automatic sync_timing();
        int   n_low;
        int   n_period;
        logic old_hs;
        wait_for_pos(0, V_ACTIVE + V_FRONT);
        check(vs_falls >= 2, 1'b1, "two vsync falls seen");
        check(last_fall - prev_fall, FRAME_CYCLES, "vsync period");
        n_low = 0;
        while (!smp_vsync) begin
            n_low++;
            tick();
        end
        check(n_low, int'(V_SYNC) * int'(H_TOTAL), "vsync low cycles");
        old_hs = 1'b0;
        while (!(old_hs && !smp_hsync)) begin
            old_hs = smp_hsync;
            tick();
        end
        check(pos_h, H_ACTIVE + H_FRONT, "column of hsync fall");
        n_low = 0;
        while (!smp_hsync) begin
            n_low++;
            tick();
        end
        check(n_low, H_SYNC, "hsync low cycles");
        n_period = n_low;
        while (smp_hsync) begin
            n_period++;
            tick();
        end
        check(n_period, H_TOTAL, "hsync period");
    endtask

    task automatic charge_and_throw(input int k);
        hold_and_release(k * STEP_CYCLES + 8);   // half a step of margin either way
        await_throw(k, $sformatf("throw with k=%0d", k));
    endtask

    task automatic saturation();
        hold_and_release(200 * STEP_CYCLES);
        await_throw(BAR_MAX_WIDTH, "saturated throw");
    endtask

    task automatic bar_overlay();
        tick();
        space <= 1'b1;
        repeat (200 * STEP_CYCLES) tick();   // width is pinned at the maximum by now
        wait_for_pos(0, BAR_Y_START - BAR_BORDER);
        repeat ((BAR_Y_END - BAR_Y_START + 2 * BAR_BORDER) * H_TOTAL) begin
            check(smp_rgb, expected_pixel(pos_h, pos_v, 1'b1, BAR_MAX_WIDTH),
                  $sformatf("bar rgb at (%0d,%0d)", pos_h, pos_v));
            tick();
        end
        space <= 1'b0;
        await_throw(BAR_MAX_WIDTH, "throw after bar frame");
    endtask

    initial begin
        rst   = 1'b1;
        space = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        while (!pos_known) tick();
        check(smp_valid, 1'b0, "throw_valid after reset");
        check(smp_force, 0, "throw_force after reset");
        background_frame();
        sync_timing();
        charge_and_throw(5);
        charge_and_throw(11);
        saturation();
        bar_overlay();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
